/* Makefile */
# Verilator build and run of the egress metadata stage testbench

TOP := tb_tsn_egress

.PHONY: all lint clean

# build, run, and pass only if the pass line shows up
all:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* apb_cfg_regs.sv */
// APB configuration slave, control, slot length, queue status and drop counter
`timescale 1ns/100ps

module apb_cfg_regs import tsn_pkg::*; #(
	parameter int RST_SLOT_LEN = 64
) (
	input  logic       clk,
	input  logic       rst_n,
	input  apb_addr_t  paddr,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  apb_data_t  pwdata,
	output apb_data_t  prdata,
	output logic       pready,
	output logic       pslverr,
	input  qcnt_t      cnt0,
	input  qcnt_t      cnt1,
	input  qcnt_t      cnt2,
	input  qcnt_t      cnt3,
	input  drop_inc_t  drop,
	output logic       enable,
	output logic [3:0] gate_mask,
	output slot_len_t  slot_len
);

	logic        access;
	logic        wr_en;
	logic        addr_ok;
	logic [15:0] drop_cnt;
	logic [16:0] drop_sum;

	// access phase, pready tied high so one cycle each
	assign access  = psel && penable;
	assign pready  = 1'b1;
	assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_SLOT)
		|| (paddr == ADDR_STATUS) || (paddr == ADDR_DROP);
	assign pslverr = access && !addr_ok;
	assign wr_en   = access && pwrite;

	// saturate at all ones
	assign drop_sum = {1'b0, drop_cnt} + 17'(drop);

	// ************************************************************
	// register writes
	// ************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable    <= 1'b0;
			gate_mask <= 4'hF;
			slot_len  <= slot_len_t'(RST_SLOT_LEN);
			drop_cnt  <= '0;
		end else begin
			if (wr_en && paddr == ADDR_CTRL) begin
				enable    <= pwdata[0];
				gate_mask <= pwdata[4:1];
			end
			if (wr_en && paddr == ADDR_SLOT) begin
				slot_len <= pwdata[15:0];
			end
			// clear keeps drops from the same cycle
			if (wr_en && paddr == ADDR_DROP) begin
				drop_cnt <= 16'(drop);
			end else if (drop_sum[16]) begin
				drop_cnt <= 16'hFFFF;
			end else begin
				drop_cnt <= drop_sum[15:0];
			end
		end
	end

	// ************************************************************
	// read mux
	// ************************************************************
	always_comb begin
		case (paddr)
			ADDR_CTRL:   prdata = {27'd0, gate_mask, enable};
			ADDR_SLOT:   prdata = {16'd0, slot_len};
			// q0 in the low bits
			ADDR_STATUS: prdata = {12'd0, cnt3, cnt2, cnt1, cnt0};
			ADDR_DROP:   prdata = {16'd0, drop_cnt};
			default:     prdata = '0;
		endcase
	end

endmodule

/* build.f */
tsn_pkg.sv
md_fifo.sv
md_buffer.sv
slot_timer.sv
tx_sched_fsm.sv
apb_cfg_regs.sv
tsn_egress.sv
tsn_egress_assert.sv
tb_tsn_egress.sv

/* md_buffer.sv */
// four egress metadata queues with head selection for the scheduler and drop merging
`timescale 1ns/100ps

module md_buffer import tsn_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	input  qmd_t       md0,
	input  qmd_t       md1,
	input  q2md_t      md2,
	input  qmd_t       md3,
	input  logic       md0_wr,
	input  logic       md1_wr,
	input  logic       md2_wr,
	input  logic       md3_wr,
	input  logic       pop,
	input  qid_t       pop_qid,
	output logic [3:0] empty,
	output qcnt_t      cnt0,
	output qcnt_t      cnt1,
	output qcnt_t      cnt2,
	output qcnt_t      cnt3,
	output md_t        head_md,
	output logic       head_outport,
	output pkt_len_t   head_len,
	output drop_inc_t  drop
);

	logic [3:0] rd;
	logic [3:0] q_drop;
	qmd_t       q0_dout;
	qmd_t       q1_dout;
	q2md_t      q2_dout;
	qmd_t       q3_dout;

	// one-hot read strobe from the pop queue number
	assign rd = pop ? (4'b0001 << pop_qid) : 4'b0000;

	// ************************************************************
	// queues
	// ************************************************************
	// even-slot scheduled traffic
	md_fifo #(.WIDTH($bits(qmd_t)), .DEPTH(FIFO_DEPTH)) q0_fifo (
		.clk(clk), .rst_n(rst_n), .din(md0), .wr(md0_wr), .rd(rd[0]),
		.dout(q0_dout), .count(cnt0), .empty(empty[0]), .full(), .drop(q_drop[0])
	);

	// odd-slot scheduled traffic
	md_fifo #(.WIDTH($bits(qmd_t)), .DEPTH(FIFO_DEPTH)) q1_fifo (
		.clk(clk), .rst_n(rst_n), .din(md1), .wr(md1_wr), .rd(rd[1]),
		.dout(q1_dout), .count(cnt1), .empty(empty[1]), .full(), .drop(q_drop[1])
	);

	// reserved bandwidth / timing, wider entry with length
	md_fifo #(.WIDTH($bits(q2md_t)), .DEPTH(FIFO_DEPTH)) q2_fifo (
		.clk(clk), .rst_n(rst_n), .din(md2), .wr(md2_wr), .rd(rd[2]),
		.dout(q2_dout), .count(cnt2), .empty(empty[2]), .full(), .drop(q_drop[2])
	);

	// best effort
	md_fifo #(.WIDTH($bits(qmd_t)), .DEPTH(FIFO_DEPTH)) q3_fifo (
		.clk(clk), .rst_n(rst_n), .din(md3), .wr(md3_wr), .rd(rd[3]),
		.dout(q3_dout), .count(cnt3), .empty(empty[3]), .full(), .drop(q_drop[3])
	);

	// ************************************************************
	// head mux and drop merge
	// ************************************************************
	always_comb begin
		head_md      = q3_dout[7:0];
		head_outport = q3_dout[8];
		// length only exists for q2
		head_len     = '0;
		case (pop_qid)
			2'd0: begin
				head_md      = q0_dout[7:0];
				head_outport = q0_dout[8];
			end
			2'd1: begin
				head_md      = q1_dout[7:0];
				head_outport = q1_dout[8];
			end
			2'd2: begin
				head_md      = q2_dout[7:0];
				head_outport = q2_dout[8];
				head_len     = q2_dout[19:9];
			end
			default: ;
		endcase
	end

	// drops from several queues in one cycle add up
	assign drop = drop_inc_t'(q_drop[0]) + drop_inc_t'(q_drop[1])
		+ drop_inc_t'(q_drop[2]) + drop_inc_t'(q_drop[3]);

endmodule

/* md_fifo.sv */
// behavioural first-word-fall-through FIFO for one metadata queue, head visible on dout
`timescale 1ns/100ps

module md_fifo import tsn_pkg::*; #(
	parameter int WIDTH = 9,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] din,
	input  logic             wr,
	input  logic             rd,
	output logic [WIDTH-1:0] dout,
	output qcnt_t            count,
	output logic             empty,
	output logic             full,
	output logic             drop
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    rd_ptr;
	logic [AW-1:0]    wr_ptr;
	logic             do_wr;
	logic             do_rd;

	// pointer advance, wraps at DEPTH-1 so any depth works
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		ptr_inc = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == qcnt_t'(DEPTH));

	// read only from a non-empty queue
	assign do_rd = rd && !empty;
	// a read frees a slot in the same edge, so full+rd still accepts
	assign do_wr = wr && (!full || do_rd);
	// entry lost
	assign drop  = wr && full && !do_rd;

	// fall-through head
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + qcnt_t'(do_wr) - qcnt_t'(do_rd);
		end
	end

endmodule

/* slot_timer.sv */
// slot counter for the gate schedule, gives the even/odd slot and a slot-start pulse
`timescale 1ns/100ps

module slot_timer import tsn_pkg::*; #(
	parameter int RST_SLOT_LEN = 64
) (
	input  logic      clk,
	input  logic      rst_n,
	input  slot_len_t slot_len,
	output logic      slot_odd,
	output logic      slot_start
);

	slot_len_t cyc_cnt;
	// length of the running slot, new value taken at each boundary
	slot_len_t cur_len;
	slot_len_t next_len;
	logic      wrap;

	// zero length runs as one-cycle slots
	assign next_len = (slot_len == '0) ? slot_len_t'(1) : slot_len;

	// last cycle of the running slot
	assign wrap = (cyc_cnt >= cur_len - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc_cnt    <= '0;
			cur_len    <= slot_len_t'(RST_SLOT_LEN);
			slot_odd   <= 1'b0;
			slot_start <= 1'b0;
		end else begin
			slot_start <= wrap;
			if (wrap) begin
				cyc_cnt  <= '0;
				cur_len  <= next_len;
				// parity flips on the same edge as the pulse
				slot_odd <= ~slot_odd;
			end else begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

endmodule

/* tb_tsn_egress.sv */
// testbench for the egress metadata stage, drives APB setup and queue writes and checks every transmit
`timescale 1ns/100ps

module tb_tsn_egress import tsn_pkg::*; ();

	localparam int DEPTH    = 16;
	localparam int SLOT_RST = 64;
	// entries per test, also sets the watchdog budget
	localparam int N_FILL = 8;
	localparam int N_PRIO = 8;
	localparam int N_GATE = 6;
	localparam int N_BP   = 10;
	localparam int N_OVF  = 20;
	localparam int ENTRIES = 4 * N_FILL + 2 * N_PRIO + 3 * N_GATE + 4 * N_BP + N_OVF;
	// worst case per entry, back-pressure plus slot waits
	localparam int CYC_PER_ENTRY   = 16;
	localparam int WATCHDOG_CYCLES = ENTRIES * CYC_PER_ENTRY + 1000;
	localparam int DRAIN_LIMIT     = 1000;

	logic      clk;
	logic      rst_n;
	qmd_t      md0;
	qmd_t      md1;
	q2md_t     md2;
	qmd_t      md3;
	logic      md0_wr;
	logic      md1_wr;
	logic      md2_wr;
	logic      md3_wr;
	md_t       tx_md;
	logic      tx_outport;
	pkt_len_t  tx_len;
	qid_t      tx_qid;
	logic      tx_valid;
	logic      tx_ready;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      slot_odd;
	logic      slot_start;

	// reference model, raw entries per queue in write order
	logic [19:0] exp_q [4][$];
	int          errors;
	int          n_tx;
	// queues that may transmit right now
	logic [3:0]  allowed;
	logic        prio_check;
	logic        seen_q3;
	// monitor history for the pop-cycle slot parity
	logic        last_valid;
	logic        last_odd;
	logic        pick_odd;

	tsn_egress #(.FIFO_DEPTH(DEPTH), .RST_SLOT_LEN(SLOT_RST)) tsn_egress_i (
		.clk(clk), .rst_n(rst_n),
		.md0(md0), .md0_wr(md0_wr), .md1(md1), .md1_wr(md1_wr),
		.md2(md2), .md2_wr(md2_wr), .md3(md3), .md3_wr(md3_wr),
		.tx_md(tx_md), .tx_outport(tx_outport), .tx_len(tx_len), .tx_qid(tx_qid),
		.tx_valid(tx_valid), .tx_ready(tx_ready),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.slot_odd(slot_odd), .slot_start(slot_start)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// ************************************************************
	// reference model and checking
	// ************************************************************
	// expected record {qid, len, outport, md}, length only for q2
	function automatic logic [21:0] expected_tx(input qid_t q, input logic [19:0] e);
		pkt_len_t len;
		len = (q == 2'd2) ? e[19:9] : '0;
		return {q, len, e[8], e[7:0]};
	endfunction

	function automatic int pending(input logic [3:0] mask);
		int n;
		n = 0;
		for (int i = 0; i < 4; i++) begin
			if (mask[i]) begin
				n += exp_q[i].size();
			end
		end
		return n;
	endfunction

	// fill counts as STATUS shows them, q0 lowest
	function automatic apb_data_t status_word();
		return {12'd0, 5'(exp_q[3].size()), 5'(exp_q[2].size()),
			5'(exp_q[1].size()), 5'(exp_q[0].size())};
	endfunction

	task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, act, exp);
			errors++;
		end
	endtask

	task automatic check_tx();
		qid_t        q;
		logic [19:0] e;
		q = tx_qid;
		n_tx++;
		if (!allowed[q]) begin
			$display("queue %0d sent an entry while its gate was masked", q);
			errors++;
		end
		// q0 pops in even slots, q1 in odd ones
		if (q == 2'd0 || q == 2'd1) begin
			check_val(32'(pick_odd), 32'(q), "slot parity at pop");
		end
		if (q == 2'd3) begin
			seen_q3 = 1'b1;
		end
		if (q == 2'd2 && seen_q3) begin
			$display("a q2 entry was sent after a q3 entry");
			errors++;
		end
		if (exp_q[q].size() == 0) begin
			$display("queue %0d sent an entry that was never written", q);
			errors++;
		end else begin
			e = exp_q[q].pop_front();
			check_val(32'({tx_qid, tx_len, tx_outport, tx_md}), 32'(expected_tx(q, e)),
				"transmit record");
		end
	endtask

	// sampled mid-cycle, handshake completes on the next rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			last_valid = 1'b0;
			last_odd   = 1'b0;
			pick_odd   = 1'b0;
			seen_q3    = 1'b0;
			n_tx       = 0;
		end else begin
			// valid just rose, so the previous cycle was POP
			if (tx_valid && !last_valid) begin
				pick_odd = last_odd;
			end
			// slot start pulses on the edge where the parity flipped
			check_val(32'(slot_start), 32'(slot_odd ^ last_odd),
				"slot_start against parity change");
			if (!prio_check) begin
				seen_q3 = 1'b0;
			end
			if (tx_valid && tx_ready) begin
				check_tx();
			end
			last_valid = tx_valid;
			last_odd   = slot_odd;
		end
	end

	// ************************************************************
	// stimulus tasks, all entered 2 ns after a rising edge
	// ************************************************************
	task automatic next_cycle();
		@(posedge clk);
		#2;
		md0_wr = 1'b0;
		md1_wr = 1'b0;
		md2_wr = 1'b0;
		md3_wr = 1'b0;
	endtask

	// strobe for this cycle, model tracks what a full queue drops
	task automatic drive_md(input qid_t q, input logic [19:0] d);
		case (q)
			2'd0: begin
				md0    = d[8:0];
				md0_wr = 1'b1;
			end
			2'd1: begin
				md1    = d[8:0];
				md1_wr = 1'b1;
			end
			2'd2: begin
				md2    = d;
				md2_wr = 1'b1;
			end
			default: begin
				md3    = d[8:0];
				md3_wr = 1'b1;
			end
		endcase
		if (exp_q[q].size() < DEPTH) begin
			exp_q[q].push_back((q == 2'd2) ? d : {11'd0, d[8:0]});
		end
	endtask

	task automatic write_md(input qid_t q, input logic [19:0] d);
		drive_md(q, d);
		next_cycle();
	endtask

	task automatic apb_write(input apb_addr_t a, input apb_data_t d);
		paddr   = a;
		pwdata  = d;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		next_cycle();
		penable = 1'b1;
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
		paddr   = a;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		next_cycle();
		penable = 1'b1;
		// access phase, read data stable at the falling edge
		@(negedge clk);
		d   = prdata;
		err = pslverr;
		check_val(32'(pready), 32'd1, "pready in access phase");
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_check(input apb_addr_t a, input apb_data_t exp, input string what);
		apb_data_t d;
		logic      err;
		apb_read(a, d, err);
		check_val(d, exp, what);
		check_val(32'(err), 32'd0, {what, " pslverr"});
	endtask

	// until the model queues in mask are empty, bounded
	task automatic wait_drain(input logic [3:0] mask, input logic rand_ready);
		int n;
		n = 0;
		while (pending(mask) != 0 && n < DRAIN_LIMIT) begin
			if (rand_ready) begin
				tx_ready = ($urandom % 2) == 1;
			end
			next_cycle();
			n++;
		end
		if (pending(mask) != 0) begin
			$display("queues %b still hold %0d entries after %0d cycles",
				mask, pending(mask), DRAIN_LIMIT);
			errors++;
		end
		tx_ready = 1'b1;
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!tx_valid && n < 50) begin
			next_cycle();
			n++;
		end
		if (!tx_valid) begin
			$display("tx_valid never rose after the scheduler was enabled");
			errors++;
		end
	endtask

	// ************************************************************
	// tests
	// ************************************************************
	task automatic test_registers();
		apb_data_t d;
		logic      err;
		// tx_valid, slot_start, slot_odd and pslverr all low out of reset
		check_val(32'({tx_valid, slot_start, slot_odd, pslverr}), 32'd0, "outputs after reset");
		// enable 0, gate mask all ones
		read_check(ADDR_CTRL, 32'h1E, "CTRL reset");
		read_check(ADDR_SLOT, 32'(SLOT_RST), "SLOT reset");
		read_check(ADDR_STATUS, 32'h0, "STATUS reset");
		read_check(ADDR_DROP, 32'h0, "DROP reset");
		apb_write(ADDR_CTRL, 32'h0B);
		read_check(ADDR_CTRL, 32'h0B, "CTRL write");
		apb_write(ADDR_SLOT, 32'h0123);
		read_check(ADDR_SLOT, 32'h0123, "SLOT write");
		apb_read(8'h10, d, err);
		check_val(32'(err), 32'd1, "pslverr on unknown address");
		check_val(d, 32'h0, "read data of unknown address");
		apb_write(8'h10, 32'hFFFF_FFFF);
		read_check(ADDR_CTRL, 32'h0B, "CTRL after unknown write");
		apb_write(ADDR_CTRL, 32'h1E);
		apb_write(ADDR_SLOT, 32'(SLOT_RST));
	endtask

	task automatic test_fifo_order();
		allowed = 4'hF;
		for (int i = 0; i < N_FILL; i++) begin
			for (int q = 0; q < 4; q++) begin
				write_md(qid_t'(q), 20'($urandom));
			end
		end
		read_check(ADDR_STATUS, status_word(), "STATUS after fill");
		tx_ready = 1'b1;
		apb_write(ADDR_CTRL, 32'h1F);
		wait_drain(4'hF, 1'b0);
		apb_write(ADDR_CTRL, 32'h1E);
		read_check(ADDR_STATUS, 32'h0, "STATUS after drain");
	endtask

	task automatic test_priority();
		// q2 and q3 open, q0/q1 masked
		apb_write(ADDR_CTRL, 32'h18);
		allowed  = 4'b1100;
		tx_ready = 1'b0;
		for (int i = 0; i < N_PRIO; i++) begin
			write_md(2'd2, 20'($urandom));
			write_md(2'd3, 20'($urandom));
		end
		prio_check = 1'b1;
		apb_write(ADDR_CTRL, 32'h19);
		wait_valid();
		check_val(32'(tx_qid), 32'd2, "first queue offered");
		tx_ready = 1'b1;
		wait_drain(4'b1100, 1'b0);
		prio_check = 1'b0;
		apb_write(ADDR_CTRL, 32'h1E);
	endtask

	task automatic test_gates();
		apb_write(ADDR_SLOT, 32'd40);
		apb_write(ADDR_CTRL, 32'h06);
		allowed = 4'b0011;
		for (int i = 0; i < N_GATE; i++) begin
			write_md(2'd0, 20'($urandom));
			write_md(2'd1, 20'($urandom));
			write_md(2'd3, 20'($urandom));
		end
		apb_write(ADDR_CTRL, 32'h07);
		wait_drain(4'b0011, 1'b0);
		// q3 still parked behind its closed gate
		read_check(ADDR_STATUS, status_word(), "STATUS with q3 masked");
		allowed = 4'hF;
		apb_write(ADDR_CTRL, 32'h1F);
		wait_drain(4'hF, 1'b0);
		apb_write(ADDR_CTRL, 32'h1E);
	endtask

	task automatic test_backpressure();
		int tx_before;
		tx_before = n_tx;
		apb_write(ADDR_CTRL, 32'h1F);
		for (int i = 0; i < 4 * N_BP; i++) begin
			drive_md(qid_t'(i % 4), 20'($urandom));
			tx_ready = ($urandom % 2) == 1;
			next_cycle();
		end
		wait_drain(4'hF, 1'b1);
		apb_write(ADDR_CTRL, 32'h1E);
		check_val(32'(n_tx - tx_before), 32'(4 * N_BP), "entries sent under back-pressure");
	endtask

	task automatic test_overflow();
		apb_write(ADDR_DROP, 32'h0);
		for (int i = 0; i < N_OVF; i++) begin
			write_md(2'd3, 20'($urandom));
		end
		// q3 count sits in bits 19..15
		read_check(ADDR_STATUS, 32'(DEPTH) << 15, "STATUS at overflow");
		read_check(ADDR_DROP, 32'(N_OVF - DEPTH), "DROP after overflow");
		apb_write(ADDR_DROP, 32'h0);
		read_check(ADDR_DROP, 32'h0, "DROP after clear");
		apb_write(ADDR_CTRL, 32'h1F);
		wait_drain(4'hF, 1'b0);
		apb_write(ADDR_CTRL, 32'h1E);
		read_check(ADDR_STATUS, 32'h0, "STATUS after overflow drain");
	endtask

	initial begin
		void'($urandom(38152));
		clk        = 1'b0;
		rst_n      = 1'b0;
		md0        = '0;
		md1        = '0;
		md2        = '0;
		md3        = '0;
		md0_wr     = 1'b0;
		md1_wr     = 1'b0;
		md2_wr     = 1'b0;
		md3_wr     = 1'b0;
		tx_ready   = 1'b0;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		errors     = 0;
		allowed    = 4'hF;
		prio_check = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_registers();
		test_fifo_order();
		test_priority();
		test_gates();
		test_backpressure();
		test_overflow();
		repeat (4) next_cycle();
		$display("errors: %0d, transmits checked: %0d", errors, n_tx);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* tsn_egress.sv */
// top level of the egress metadata stage, queues, slot timer, scheduler and APB registers
`timescale 1ns/100ps

module tsn_egress import tsn_pkg::*; #(
	parameter int FIFO_DEPTH   = 16,
	parameter int RST_SLOT_LEN = 64
) (
	input  logic      clk,
	input  logic      rst_n,
	// metadata in
	input  qmd_t      md0,
	input  logic      md0_wr,
	input  qmd_t      md1,
	input  logic      md1_wr,
	input  q2md_t     md2,
	input  logic      md2_wr,
	input  qmd_t      md3,
	input  logic      md3_wr,
	// transmit side
	output md_t       tx_md,
	output logic      tx_outport,
	output pkt_len_t  tx_len,
	output qid_t      tx_qid,
	output logic      tx_valid,
	input  logic      tx_ready,
	// apb
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	// slot status
	output logic      slot_odd,
	output logic      slot_start
);

	logic       enable;
	logic [3:0] gate_mask;
	slot_len_t  slot_len;
	logic [3:0] empty;
	qcnt_t      cnt0;
	qcnt_t      cnt1;
	qcnt_t      cnt2;
	qcnt_t      cnt3;
	md_t        head_md;
	logic       head_outport;
	pkt_len_t   head_len;
	drop_inc_t  drop;
	logic       pop;
	qid_t       pop_qid;

	md_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) md_buffer_i (
		.clk(clk), .rst_n(rst_n),
		.md0(md0), .md1(md1), .md2(md2), .md3(md3),
		.md0_wr(md0_wr), .md1_wr(md1_wr), .md2_wr(md2_wr), .md3_wr(md3_wr),
		.pop(pop), .pop_qid(pop_qid), .empty(empty),
		.cnt0(cnt0), .cnt1(cnt1), .cnt2(cnt2), .cnt3(cnt3),
		.head_md(head_md), .head_outport(head_outport), .head_len(head_len), .drop(drop)
	);

	slot_timer #(.RST_SLOT_LEN(RST_SLOT_LEN)) slot_timer_i (
		.clk(clk), .rst_n(rst_n), .slot_len(slot_len),
		.slot_odd(slot_odd), .slot_start(slot_start)
	);

	tx_sched_fsm tx_sched_fsm_i (
		.clk(clk), .rst_n(rst_n), .enable(enable), .gate_mask(gate_mask),
		.slot_odd(slot_odd), .empty(empty),
		.head_md(head_md), .head_outport(head_outport), .head_len(head_len),
		.tx_ready(tx_ready), .pop(pop), .pop_qid(pop_qid),
		.tx_md(tx_md), .tx_outport(tx_outport), .tx_len(tx_len),
		.tx_qid(tx_qid), .tx_valid(tx_valid)
	);

	apb_cfg_regs #(.RST_SLOT_LEN(RST_SLOT_LEN)) apb_cfg_regs_i (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cnt0(cnt0), .cnt1(cnt1), .cnt2(cnt2), .cnt3(cnt3), .drop(drop),
		.enable(enable), .gate_mask(gate_mask), .slot_len(slot_len)
	);

endmodule

/* tsn_egress_assert.sv */
// scheduler assertions, bound into every tx_sched_fsm instance
`timescale 1ns/100ps

module tsn_egress_assert import tsn_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       tx_valid,
	input logic       tx_ready,
	input md_t        tx_md,
	input logic       tx_outport,
	input pkt_len_t   tx_len,
	input qid_t       tx_qid,
	input logic       pop,
	input qid_t       pop_qid,
	input logic       slot_odd,
	input logic [3:0] empty
);

	// offered entry held until accepted
	assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable({tx_md, tx_outport, tx_len, tx_qid}))
		else $error("tx_valid or its fields changed before tx_ready");

	// ************************************************************
	// gate rules at the pop
	// ************************************************************
	assert property (@(posedge clk) disable iff (!rst_n)
		pop && pop_qid == 2'd0 |-> !slot_odd)
		else $error("q0 popped in an odd slot");

	assert property (@(posedge clk) disable iff (!rst_n)
		pop && pop_qid == 2'd1 |-> slot_odd)
		else $error("q1 popped in an even slot");

	assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty[pop_qid])
		else $error("pop targets an empty queue");

endmodule

bind tx_sched_fsm tsn_egress_assert tsn_egress_assert_i (
	.clk(clk), .rst_n(rst_n), .tx_valid(tx_valid), .tx_ready(tx_ready),
	.tx_md(tx_md), .tx_outport(tx_outport), .tx_len(tx_len), .tx_qid(tx_qid),
	.pop(pop), .pop_qid(pop_qid), .slot_odd(slot_odd), .empty(empty)
);

/* tsn_pkg.sv */
// shared types and register map for the egress metadata stage, imported by every design module
package tsn_pkg;

	// ************************************************************
	// metadata widths
	// ************************************************************
	// descriptor byte handed to the transmitter
	typedef logic [7:0]  md_t;
	// q0/q1/q3 entry, outport flag on top of the byte
	typedef logic [8:0]  qmd_t;
	typedef logic [10:0] pkt_len_t;
	// q2 entry: {len, outport, md}
	typedef logic [19:0] q2md_t;

	// fill count, holds 0..16
	typedef logic [4:0]  qcnt_t;
	typedef logic [1:0]  qid_t;
	// slot length in clock cycles
	typedef logic [15:0] slot_len_t;
	// dropped entries in one cycle, up to four at once
	typedef logic [2:0]  drop_inc_t;

	// ************************************************************
	// apb register map
	// ************************************************************
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	localparam apb_addr_t ADDR_CTRL   = 8'h00;
	localparam apb_addr_t ADDR_SLOT   = 8'h04;
	localparam apb_addr_t ADDR_STATUS = 8'h08;
	localparam apb_addr_t ADDR_DROP   = 8'h0C;

	// scheduler states
	typedef enum logic [1:0] {
		IDLE,
		POP,
		SEND
	} sched_state_t;

endpackage

/* tx_sched_fsm.sv */
// transmit scheduler, gates and prioritises the four queues and hands one entry to the transmitter
`timescale 1ns/100ps

module tx_sched_fsm import tsn_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       enable,
	input  logic [3:0] gate_mask,
	input  logic       slot_odd,
	input  logic [3:0] empty,
	input  md_t        head_md,
	input  logic       head_outport,
	input  pkt_len_t   head_len,
	input  logic       tx_ready,
	output logic       pop,
	output qid_t       pop_qid,
	output md_t        tx_md,
	output logic       tx_outport,
	output pkt_len_t   tx_len,
	output qid_t       tx_qid,
	output logic       tx_valid
);

	sched_state_t state;
	sched_state_t state_nxt;
	logic [3:0]   gate_open;
	logic [3:0]   eligible;
	logic         pick_ok;
	qid_t         pick_nxt;
	qid_t         pick_qid;

	// ************************************************************
	// gate evaluation and priority
	// ************************************************************
	// q0 even slots, q1 odd slots, q2/q3 by mask only
	assign gate_open[0] = gate_mask[0] & ~slot_odd;
	assign gate_open[1] = gate_mask[1] & slot_odd;
	assign gate_open[2] = gate_mask[2];
	assign gate_open[3] = gate_mask[3];

	assign eligible = gate_open & ~empty;
	assign pick_ok  = enable && (|eligible);

	// q0 and q1 never open together, so their order is free
	always_comb begin
		if (eligible[0]) begin
			pick_nxt = 2'd0;
		end else if (eligible[1]) begin
			pick_nxt = 2'd1;
		end else if (eligible[2]) begin
			pick_nxt = 2'd2;
		end else begin
			pick_nxt = 2'd3;
		end
	end

	// ************************************************************
	// state machine
	// ************************************************************
	always_comb begin
		state_nxt = state;
		pop       = 1'b0;
		case (state)
			IDLE: begin
				if (pick_ok) begin
					state_nxt = POP;
				end
			end
			POP: begin
				// slot may have flipped since the pick, then give up this round
				if (gate_open[pick_qid]) begin
					pop       = 1'b1;
					state_nxt = SEND;
				end else begin
					state_nxt = IDLE;
				end
			end
			SEND: begin
				if (tx_ready) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			pick_qid <= '0;
		end else begin
			state <= state_nxt;
			if (state == IDLE && pick_ok) begin
				pick_qid <= pick_nxt;
			end
		end
	end

	// head fields captured on the pop edge, held through SEND
	always_ff @(posedge clk) begin
		if (pop) begin
			tx_md      <= head_md;
			tx_outport <= head_outport;
			tx_len     <= head_len;
		end
	end

	// pick only changes in IDLE, so it is stable while valid
	assign pop_qid  = pick_qid;
	assign tx_qid   = pick_qid;
	assign tx_valid = (state == SEND);

endmodule
